//--- all.f
+incdir+.
simt_pkg.sv
simt_reg_file.sv
simt_fetch.sv
simt_decode.sv
simt_d_e_reg.sv
simt_execute.sv
simt_wb_arbiter.sv
simt_core.sv
simt_core_props.sv
simt_core_tb.sv

//--- Bender.yml
package:
  name: simt_core

sources:
  - include_dirs:
      - .
    files:
      - simt_pkg.sv
      - simt_reg_file.sv
      - simt_fetch.sv
      - simt_decode.sv
      - simt_d_e_reg.sv
      - simt_execute.sv
      - simt_wb_arbiter.sv
      - simt_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - simt_core_props.sv
      - simt_core_tb.sv

//--- simt_core_tb.sv
`timescale 1ns/100ps

module simt_core_tb;
	import simt_pkg::*;

	localparam int ROWS     = 10;
	localparam int MAX_PROG = 16;
	localparam int MAX_ST   = 4;

	logic  clk;
	logic  rst;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	addr_t wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic  wb_ack;

	string name [ROWS];
	word_t prog [ROWS][MAX_PROG];
	bit    rand_delay [ROWS];
	int    n_st [ROWS];
	addr_t exp_adr [ROWS][MAX_ST];
	word_t exp_dat [ROWS][MAX_ST];

	word_t mem [256];
	bit    delay_en;
	logic  pending;
	int    wait_left;
	addr_t got_adr [$];
	word_t got_dat [$];
	int    errs;
	int    pass_cnt;
	int    fail_cnt;
	int    row;
	int    pc_i;

	simt_core simt_core_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t r_word(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t i_word(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
		logic [11:0] im;
		im = 12'(imm);
		return {im, 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic word_t s_word(int rs2, int rs1, int imm);
		logic [11:0] im;
		im = 12'(imm);
		return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_word(logic [2:0] f3, int rs1, int rs2, int off);
		logic [12:0] im;
		im = 13'(off);
		return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
	endfunction

	function automatic word_t j_word(int rd, int off);
		logic [20:0] im;
		im = 21'(off);
		return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic word_t lui_word(int rd, logic [19:0] upper);
		return {upper, 5'(rd), 7'b0110111};
	endfunction

	task automatic emit(word_t w);
		prog[row][pc_i] = w;
		pc_i++;
	endtask

	task automatic expect_store(addr_t a, word_t d);
		exp_adr[row][n_st[row]] = a;
		exp_dat[row][n_st[row]] = d;
		n_st[row]++;
	endtask

	task automatic begin_row(string nm);
		name[row]       = nm;
		rand_delay[row] = 1'b0;
		n_st[row]       = 0;
		pc_i            = 0;
		for (int i = 0; i < MAX_PROG; i++)
			prog[row][i] = j_word(0, 0); // self loop parks the core
		emit(r_word(7'h00, 3'b000, 5, 31, 31)); // x5 = 4 * tid
		emit(r_word(7'h00, 3'b000, 5, 5, 5));
	endtask

	task automatic check_addr(string nm, addr_t exp, addr_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s address expected %h actual %h", nm, exp, act);
			errs++;
		end
	endtask

	task automatic check_data(string nm, word_t exp, word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s data expected %h actual %h", nm, exp, act);
			errs++;
		end
	endtask

	task automatic build_table();
		row = 0;
		begin_row("alu_ops");
		emit(i_word(7'b0010011, 3'b000, 1, 31, 100));
		emit(lui_word(2, 20'h12345));
		emit(r_word(7'h00, 3'b000, 3, 2, 1)); // add
		emit(r_word(7'h00, 3'b100, 4, 3, 1)); // xor
		emit(r_word(7'h00, 3'b110, 6, 3, 2)); // or
		emit(r_word(7'h00, 3'b111, 7, 4, 3)); // and
		emit(r_word(7'h20, 3'b000, 8, 7, 1)); // sub
		emit(s_word(6, 5, 'h300));
		emit(s_word(8, 5, 'h308));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h300 + 4 * k), 32'h12345000 + word_t'(100 + k));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h308 + 4 * k), 32'h12345000 - word_t'(100 + k));
		row = 1;
		begin_row("dep_chain");
		emit(i_word(7'b0010011, 3'b000, 1, 31, 5));
		emit(r_word(7'h00, 3'b000, 1, 1, 1));
		emit(i_word(7'b0010011, 3'b000, 1, 1, -3));
		emit(r_word(7'h20, 3'b000, 2, 1, 31));
		emit(r_word(7'h00, 3'b100, 2, 2, 1));
		emit(s_word(1, 5, 'h310));
		emit(s_word(2, 5, 'h318));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h310 + 4 * k), word_t'(7 + 2 * k));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h318 + 4 * k), word_t'((7 + k) ^ (7 + 2 * k)));
		row = 2;
		begin_row("store_load");
		emit(i_word(7'b0010011, 3'b000, 1, 31, 40));
		emit(s_word(1, 5, 'h320));
		emit(i_word(7'b0000011, 3'b010, 2, 5, 'h320)); // lw
		emit(i_word(7'b0010011, 3'b000, 3, 2, 7));
		emit(s_word(3, 5, 'h328));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h320 + 4 * k), word_t'(40 + k));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h328 + 4 * k), word_t'(47 + k));
		row = 3;
		begin_row("branches");
		emit(i_word(7'b0010011, 3'b000, 1, 31, 3));
		emit(i_word(7'b0010011, 3'b000, 2, 31, 3));
		emit(b_word(3'b000, 1, 2, 8)); // beq taken
		emit(s_word(1, 5, 'h330)); // wrong path
		emit(b_word(3'b001, 1, 2, 8)); // bne not taken
		emit(s_word(2, 5, 'h338));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h338 + 4 * k), word_t'(3 + k));
		row = 4;
		begin_row("jal_link");
		emit(j_word(1, 12)); // at pc 8, lands on 20
		emit(s_word(31, 5, 'h340));
		emit(s_word(31, 5, 'h340));
		emit(s_word(1, 5, 'h348));
		for (int k = 0; k < 2; k++)
			expect_store(addr_t'('h348 + 4 * k), word_t'(12));
		// same programs again under random ack delay
		for (int r = 5; r < ROWS; r++) begin
			name[r]       = {name[r - 5], "_rdelay"};
			prog[r]       = prog[r - 5];
			rand_delay[r] = 1'b1;
			n_st[r]       = n_st[r - 5];
			exp_adr[r]    = exp_adr[r - 5];
			exp_dat[r]    = exp_dat[r - 5];
		end
	endtask

	// wishbone slave memory
	always @(posedge clk) begin
		int cnt;
		if (rst) begin
			wb_ack  <= 1'b0;
			pending <= 1'b0;
		end else if (wb_ack) begin
			wb_ack  <= 1'b0;
			pending <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			cnt = pending ? wait_left : (delay_en ? int'($urandom_range(3, 0)) : 0);
			pending <= 1'b1;
			if (cnt == 0) begin
				wb_ack   <= 1'b1;
				wb_dat_r <= mem[wb_adr[9:2]];
				if (wb_we)
					mem[wb_adr[9:2]] = wb_dat_w;
			end else begin
				wait_left <= cnt - 1;
			end
		end
	end

	// acknowledged writes, in bus order
	always @(posedge clk) begin
		if (!rst && wb_cyc && wb_stb && wb_we && wb_ack) begin
			got_adr.push_back(wb_adr);
			got_dat.push_back(wb_dat_w);
		end
	end

	initial begin
		repeat (400 * ROWS) @(posedge clk);
		$display("timeout, stores never completed");
		$display("Verification failed");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		wb_ack    = 1'b0;
		wb_dat_r  = '0;
		pending   = 1'b0;
		wait_left = 0;
		delay_en  = 1'b0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		void'($urandom(51996));
		build_table();
		for (int r = 0; r < ROWS; r++) begin
			@(posedge clk);
			rst <= 1'b1;
			for (int i = 0; i < 256; i++)
				mem[i] = 32'hdead_0000 ^ word_t'(i * 4);
			for (int i = 0; i < MAX_PROG; i++)
				mem[i] = prog[r][i];
			delay_en = rand_delay[r];
			got_adr.delete();
			got_dat.delete();
			errs = 0;
			repeat (5) @(posedge clk);
			rst <= 1'b0;
			while (got_adr.size() < n_st[r])
				@(posedge clk);
			repeat (30) @(posedge clk); // room for a stray store
			for (int i = 0; i < n_st[r]; i++) begin
				check_addr(name[r], exp_adr[r][i], got_adr[i]);
				check_data(name[r], exp_dat[r][i], got_dat[i]);
			end
			if (got_adr.size() > n_st[r]) begin
				$display("%s wrote more stores than expected", name[r]);
				errs++;
			end
			if (errs == 0) begin
				$display("PASS %s", name[r]);
				pass_cnt++;
			end else begin
				$display("FAIL %s", name[r]);
				fail_cnt++;
			end
		end
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- simt_core_props.sv
`timescale 1ns/100ps

module simt_core_props (
	input logic                 clk,
	input logic                 rst,
	input logic                 wb_cyc,
	input logic                 wb_stb,
	input logic                 wb_we,
	input simt_pkg::addr_t      wb_adr,
	input simt_pkg::word_t      wb_dat_w,
	input logic                 wb_ack,
	input simt_pkg::lane_mask_t ex_valid,
	input logic                 redirect
);

	stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else $error("wishbone stb high without cyc");

	// request held until the slave answers
	req_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
		$stable(wb_dat_w))
		else $error("wishbone request changed before ack");

	valid_after_rst: assert property (@(posedge clk) rst |=> (ex_valid == '0))
		else $error("execute valid mask not cleared by reset");

	redirect_pulse: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
		else $error("redirect high for two cycles");

endmodule

bind simt_core simt_core_props simt_core_props_inst (
	.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .ex_valid, .redirect
);

//--- simt_core.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_core (
	input  logic            clk,
	input  logic            rst,
	output logic            wb_cyc,
	output logic            wb_stb,
	output logic            wb_we,
	output simt_pkg::addr_t wb_adr,
	output simt_pkg::word_t wb_dat_w,
	input  simt_pkg::word_t wb_dat_r,
	input  logic            wb_ack
);
	import simt_pkg::*;

	logic                           f_cyc;
	logic                           f_stb;
	addr_t                          f_adr;
	word_t                          f_dat_r;
	logic                           f_ack;
	logic                           d_cyc;
	logic                           d_stb;
	logic                           d_we;
	addr_t                          d_adr;
	word_t                          d_dat_w;
	word_t                          d_dat_r;
	logic                           d_ack;
	word_t                          instr;
	addr_t                          instr_pc;
	logic                           instr_valid;
	logic                           instr_taken;
	logic [4:0]                     rs1;
	logic [4:0]                     rs2;
	word_t [`NUM_THREADS-1:0]      rd_data1;
	word_t [`NUM_THREADS-1:0]      rd_data2;
	logic [4:0]                     dec_rd;
	word_t [`NUM_THREADS-1:0][1:0] dec_reg_data;
	alu_op_e                        dec_alu_op;
	wb_src_e                        dec_wb_src;
	mem_op_e                        dec_mem_op;
	branch_e                        dec_branch_type;
	word_t                          dec_immed;
	addr_t                          dec_curr_pc;
	lane_mask_t                     dec_valid;
	logic                           fwd_stall;
	logic                           branch_stall;
	logic [4:0]                     ex_rd;
	logic [4:0]                     ex_rs2;
	word_t [`NUM_THREADS-1:0][1:0] ex_reg_data;
	alu_op_e                        ex_alu_op;
	wb_src_e                        ex_wb_src;
	mem_op_e                        ex_mem_op;
	branch_e                        ex_branch_type;
	word_t                          ex_immed;
	addr_t                          ex_curr_pc;
	lane_mask_t                     ex_valid;
	logic                           ex_writes;
	logic                           freeze;
	logic                           redirect;
	addr_t                          redirect_pc;
	lane_mask_t                     wr_en;
	logic [4:0]                     wr_rd;
	word_t [`NUM_THREADS-1:0]      wr_data;

	assign ex_writes = (ex_valid != '0) && (ex_wb_src != WB_NONE);

	simt_fetch simt_fetch_inst (.*);

	simt_reg_file simt_reg_file_inst (.*);

	simt_decode simt_decode_inst (
		.clk, .rst, .instr, .instr_pc, .instr_valid, .instr_taken,
		.rs1, .rs2, .rd_data1, .rd_data2, .ex_rd, .ex_writes, .freeze, .redirect,
		.rd(dec_rd), .reg_data(dec_reg_data), .alu_op(dec_alu_op),
		.wb_src(dec_wb_src), .mem_op(dec_mem_op), .branch_type(dec_branch_type),
		.immed(dec_immed), .curr_pc(dec_curr_pc), .valid(dec_valid),
		.fwd_stall, .branch_stall
	);

	simt_d_e_reg simt_d_e_reg_inst (
		.clk, .rst, .freeze, .fwd_stall, .branch_stall,
		.in_rd(dec_rd), .in_rs1(rs1), .in_rs2(rs2), .in_reg_data(dec_reg_data),
		.in_alu_op(dec_alu_op), .in_wb_src(dec_wb_src), .in_mem_op(dec_mem_op),
		.in_branch_type(dec_branch_type), .in_immed(dec_immed),
		.in_curr_pc(dec_curr_pc), .in_valid(dec_valid),
		.out_rd(ex_rd), .out_rs1(), .out_rs2(ex_rs2), .out_reg_data(ex_reg_data),
		.out_alu_op(ex_alu_op), .out_wb_src(ex_wb_src), .out_mem_op(ex_mem_op),
		.out_branch_type(ex_branch_type), .out_immed(ex_immed),
		.out_curr_pc(ex_curr_pc), .out_valid(ex_valid)
	);

	simt_execute simt_execute_inst (
		.clk, .rst, .rd(ex_rd), .rs2(ex_rs2), .reg_data(ex_reg_data),
		.alu_op(ex_alu_op), .wb_src(ex_wb_src), .mem_op(ex_mem_op),
		.branch_type(ex_branch_type), .immed(ex_immed), .curr_pc(ex_curr_pc),
		.valid(ex_valid), .d_cyc, .d_stb, .d_we, .d_adr, .d_dat_w, .d_dat_r, .d_ack,
		.freeze, .redirect, .redirect_pc, .wr_en, .wr_rd, .wr_data
	);

	simt_wb_arbiter simt_wb_arbiter_inst (.*);

endmodule

//--- simt_wb_arbiter.sv
`timescale 1ns/100ps

module simt_wb_arbiter (
	input  logic            clk,
	input  logic            rst,
	input  logic            f_cyc,
	input  logic            f_stb,
	input  simt_pkg::addr_t f_adr,
	output simt_pkg::word_t f_dat_r,
	output logic            f_ack,
	input  logic            d_cyc,
	input  logic            d_stb,
	input  logic            d_we,
	input  simt_pkg::addr_t d_adr,
	input  simt_pkg::word_t d_dat_w,
	output simt_pkg::word_t d_dat_r,
	output logic            d_ack,
	output logic            wb_cyc,
	output logic            wb_stb,
	output logic            wb_we,
	output simt_pkg::addr_t wb_adr,
	output simt_pkg::word_t wb_dat_w,
	input  simt_pkg::word_t wb_dat_r,
	input  logic            wb_ack
);

	logic gnt_f;
	logic gnt_d;
	logic owner_busy;

	assign owner_busy = (gnt_d && d_cyc) || (gnt_f && f_cyc);

	// grant changes only once the owner has let go of cyc
	always_ff @(posedge clk) begin
		if (rst) begin
			gnt_f <= 1'b0;
			gnt_d <= 1'b0;
		end else if (!owner_busy) begin
			gnt_d <= d_cyc; // data master wins a tie
			gnt_f <= f_cyc && !d_cyc;
		end
	end

	assign wb_cyc   = owner_busy;
	assign wb_stb   = gnt_d ? d_stb : (gnt_f && f_stb);
	assign wb_we    = gnt_d && d_we;
	assign wb_adr   = gnt_d ? d_adr : f_adr;
	assign wb_dat_w = gnt_d ? d_dat_w : '0;

	assign f_ack   = gnt_f && wb_ack;
	assign d_ack   = gnt_d && wb_ack;
	assign f_dat_r = gnt_f ? wb_dat_r : '0;
	assign d_dat_r = gnt_d ? wb_dat_r : '0;

endmodule

//--- simt_execute.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_execute (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic [4:0]                               rd,
	input  logic [4:0]                               rs2,
	input  simt_pkg::word_t [`NUM_THREADS-1:0][1:0] reg_data,
	input  simt_pkg::alu_op_e                        alu_op,
	input  simt_pkg::wb_src_e                        wb_src,
	input  simt_pkg::mem_op_e                        mem_op,
	input  simt_pkg::branch_e                        branch_type,
	input  simt_pkg::word_t                          immed,
	input  simt_pkg::addr_t                          curr_pc,
	input  simt_pkg::lane_mask_t                     valid,
	output logic                                     d_cyc,
	output logic                                     d_stb,
	output logic                                     d_we,
	output simt_pkg::addr_t                          d_adr,
	output simt_pkg::word_t                          d_dat_w,
	input  simt_pkg::word_t                          d_dat_r,
	input  logic                                     d_ack,
	output logic                                     freeze,
	output logic                                     redirect,
	output simt_pkg::addr_t                          redirect_pc,
	output simt_pkg::lane_mask_t                     wr_en,
	output logic [4:0]                               wr_rd,
	output simt_pkg::word_t [`NUM_THREADS-1:0]      wr_data
);
	import simt_pkg::*;

	localparam int LW = (`NUM_THREADS > 1) ? $clog2(`NUM_THREADS) : 1;

	ex_state_e                 state;
	logic [LW-1:0]             lane;
	logic                      mem_item;
	logic                      last_lane;
	logic                      taken;
	addr_t                     link_pc;
	word_t [`NUM_THREADS-1:0] alu_res;

	assign mem_item  = (valid != '0) && (mem_op != MEM_NONE);
	assign last_lane = (lane == LW'(`NUM_THREADS - 1));
	assign link_pc   = curr_pc + addr_t'(4);

	always_comb begin
		word_t op_a;
		word_t op_b;
		for (int k = 0; k < `NUM_THREADS; k++) begin
			op_a = reg_data[k][0];
			op_b = (rs2 != 5'd0) ? reg_data[k][1] : immed; // x0 source takes the immediate
			case (alu_op)
				ALU_ADD:    alu_res[k] = op_a + op_b;
				ALU_SUB:    alu_res[k] = op_a - op_b;
				ALU_AND:    alu_res[k] = op_a & op_b;
				ALU_OR:     alu_res[k] = op_a | op_b;
				ALU_XOR:    alu_res[k] = op_a ^ op_b;
				ALU_PASS_B: alu_res[k] = op_b;
				default:    alu_res[k] = '0;
			endcase
		end
	end

	// lane 0 decides the direction for all lanes
	always_comb begin
		case (branch_type)
			BR_EQ:   taken = (reg_data[0][0] == reg_data[0][1]);
			BR_NE:   taken = (reg_data[0][0] != reg_data[0][1]);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect    = valid[0] && (branch_type != BR_NONE);
	assign redirect_pc = taken ? curr_pc + immed : link_pc;

	assign d_cyc   = (state == EX_MEM_REQ) && valid[lane];
	assign d_stb   = d_cyc;
	assign d_we    = d_cyc && (mem_op == MEM_STORE);
	assign d_adr   = reg_data[lane][0] + immed;
	assign d_dat_w = reg_data[lane][1];
	assign freeze  = (state == EX_RUN) ? mem_item : !(state == EX_MEM_NEXT && last_lane);
	assign wr_rd   = rd;

	always_comb begin
		for (int k = 0; k < `NUM_THREADS; k++) begin
			wr_en[k]   = 1'b0;
			wr_data[k] = (wb_src == WB_LINK) ? link_pc : alu_res[k];
			if (state == EX_RUN) begin
				wr_en[k] = valid[k] && (wb_src == WB_ALU || wb_src == WB_LINK);
			end else if (state == EX_MEM_REQ && lane == LW'(k) && d_ack &&
				mem_op == MEM_LOAD) begin
				wr_en[k]   = 1'b1;
				wr_data[k] = d_dat_r;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= EX_RUN;
			lane  <= '0;
		end else begin
			case (state)
				EX_RUN: begin
					if (mem_item)
						state <= EX_MEM_REQ;
				end
				EX_MEM_REQ: begin
					if (d_ack || !valid[lane]) // inactive lane skips the bus
						state <= EX_MEM_NEXT;
				end
				EX_MEM_NEXT: begin // cyc is low here, stb drops after ack
					lane  <= last_lane ? '0 : lane + 1'b1;
					state <= last_lane ? EX_RUN : EX_MEM_REQ;
				end
				default: state <= EX_RUN;
			endcase
		end
	end

endmodule

//--- simt_d_e_reg.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_d_e_reg (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     freeze,
	input  logic                                     fwd_stall,
	input  logic                                     branch_stall,
	input  logic [4:0]                               in_rd,
	input  logic [4:0]                               in_rs1,
	input  logic [4:0]                               in_rs2,
	input  simt_pkg::word_t [`NUM_THREADS-1:0][1:0] in_reg_data,
	input  simt_pkg::alu_op_e                        in_alu_op,
	input  simt_pkg::wb_src_e                        in_wb_src,
	input  simt_pkg::mem_op_e                        in_mem_op,
	input  simt_pkg::branch_e                        in_branch_type,
	input  simt_pkg::word_t                          in_immed,
	input  simt_pkg::addr_t                          in_curr_pc,
	input  simt_pkg::lane_mask_t                     in_valid,
	output logic [4:0]                               out_rd,
	output logic [4:0]                               out_rs1,
	output logic [4:0]                               out_rs2,
	output simt_pkg::word_t [`NUM_THREADS-1:0][1:0] out_reg_data,
	output simt_pkg::alu_op_e                        out_alu_op,
	output simt_pkg::wb_src_e                        out_wb_src,
	output simt_pkg::mem_op_e                        out_mem_op,
	output simt_pkg::branch_e                        out_branch_type,
	output simt_pkg::word_t                          out_immed,
	output simt_pkg::addr_t                          out_curr_pc,
	output simt_pkg::lane_mask_t                     out_valid
);
	import simt_pkg::*;

	logic bubble;

	assign bubble = rst || fwd_stall || branch_stall;

	always_ff @(posedge clk) begin
		if (rst || !freeze) begin // freeze holds everything
			if (bubble) begin
				out_rd          <= 5'd0;
				out_rs1         <= 5'd0;
				out_rs2         <= 5'd0;
				out_reg_data    <= '0;
				out_alu_op      <= ALU_NONE;
				out_wb_src      <= WB_NONE;
				out_mem_op      <= MEM_NONE;
				out_branch_type <= BR_NONE;
				out_immed       <= '0;
				out_curr_pc     <= '0;
				out_valid       <= '0;
			end else begin
				out_rd          <= in_rd;
				out_rs1         <= in_rs1;
				out_rs2         <= in_rs2;
				out_reg_data    <= in_reg_data;
				out_alu_op      <= in_alu_op;
				out_wb_src      <= in_wb_src;
				out_mem_op      <= in_mem_op;
				out_branch_type <= in_branch_type;
				out_immed       <= in_immed;
				out_curr_pc     <= in_curr_pc;
				out_valid       <= in_valid;
			end
		end
	end

endmodule

//--- simt_decode.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_decode (
	input  logic                                     clk,
	input  logic                                     rst,
	input  simt_pkg::word_t                          instr,
	input  simt_pkg::addr_t                          instr_pc,
	input  logic                                     instr_valid,
	output logic                                     instr_taken,
	output logic [4:0]                               rs1,
	output logic [4:0]                               rs2,
	input  simt_pkg::word_t [`NUM_THREADS-1:0]      rd_data1,
	input  simt_pkg::word_t [`NUM_THREADS-1:0]      rd_data2,
	input  logic [4:0]                               ex_rd,
	input  logic                                     ex_writes,
	input  logic                                     freeze,
	input  logic                                     redirect,
	output logic [4:0]                               rd,
	output simt_pkg::word_t [`NUM_THREADS-1:0][1:0] reg_data,
	output simt_pkg::alu_op_e                        alu_op,
	output simt_pkg::wb_src_e                        wb_src,
	output simt_pkg::mem_op_e                        mem_op,
	output simt_pkg::branch_e                        branch_type,
	output simt_pkg::word_t                          immed,
	output simt_pkg::addr_t                          curr_pc,
	output simt_pkg::lane_mask_t                     valid,
	output logic                                     fwd_stall,
	output logic                                     branch_stall
);
	import simt_pkg::*;

	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} rv_op_e;

	logic    use_rs1;
	logic    use_rs2;
	logic    issue;
	alu_op_e op_alu;
	wb_src_e op_wb;
	mem_op_e op_mem;
	branch_e op_br;

	always_comb begin
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		op_alu  = ALU_NONE;
		op_wb   = WB_NONE;
		op_mem  = MEM_NONE;
		op_br   = BR_NONE;
		immed   = '0; // R-type keeps zero so an x0 source still reads zero
		case (rv_op_e'(instr[6:0]))
			OP_REG: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				op_wb   = WB_ALU;
				case (instr[14:12])
					3'b000:  op_alu = instr[30] ? ALU_SUB : ALU_ADD;
					3'b100:  op_alu = ALU_XOR;
					3'b110:  op_alu = ALU_OR;
					3'b111:  op_alu = ALU_AND;
					default: op_wb  = WB_NONE;
				endcase
			end
			OP_IMM: begin // ADDI
				use_rs1 = 1'b1;
				op_alu  = ALU_ADD;
				op_wb   = WB_ALU;
				immed   = {{20{instr[31]}}, instr[31:20]};
			end
			OP_LUI: begin
				op_alu = ALU_PASS_B;
				op_wb  = WB_ALU;
				immed  = {instr[31:12], 12'h000};
			end
			OP_LOAD: begin
				use_rs1 = 1'b1;
				op_mem  = MEM_LOAD;
				op_wb   = WB_MEM;
				immed   = {{20{instr[31]}}, instr[31:20]};
			end
			OP_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				op_mem  = MEM_STORE;
				immed   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			OP_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				op_br   = instr[12] ? BR_NE : BR_EQ;
				immed   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			OP_JAL: begin
				op_br = BR_JAL;
				op_wb = WB_LINK;
				immed = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: ;
		endcase
	end

	// unused source fields stay zero, so they never raise a false hazard
	assign rs1 = use_rs1 ? instr[19:15] : 5'd0;
	assign rs2 = use_rs2 ? instr[24:20] : 5'd0;

	assign fwd_stall = instr_valid && ex_writes && (ex_rd != 5'd0) &&
		((rs1 == ex_rd) || (rs2 == ex_rd));
	assign issue = instr_valid && !fwd_stall && !branch_stall && !freeze && !redirect;

	assign instr_taken = issue;
	assign valid       = issue ? '1 : '0;
	assign rd          = (issue && op_wb != WB_NONE) ? instr[11:7] : 5'd0;
	assign alu_op      = issue ? op_alu : ALU_NONE;
	assign wb_src      = issue ? op_wb : WB_NONE;
	assign mem_op      = issue ? op_mem : MEM_NONE;
	assign branch_type = issue ? op_br : BR_NONE;
	assign curr_pc     = instr_pc;

	always_comb begin
		for (int k = 0; k < `NUM_THREADS; k++) begin
			reg_data[k][0] = rd_data1[k];
			reg_data[k][1] = rd_data2[k];
		end
	end

	// pending control transfer, cleared by its resolution
	always_ff @(posedge clk) begin
		if (rst || redirect)
			branch_stall <= 1'b0;
		else if (issue && op_br != BR_NONE)
			branch_stall <= 1'b1;
	end

endmodule

//--- simt_fetch.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_fetch (
	input  logic            clk,
	input  logic            rst,
	output logic            f_cyc,
	output logic            f_stb,
	output simt_pkg::addr_t f_adr,
	input  simt_pkg::word_t f_dat_r,
	input  logic            f_ack,
	output simt_pkg::word_t instr,
	output simt_pkg::addr_t instr_pc,
	output logic            instr_valid,
	input  logic            instr_taken,
	input  logic            freeze,
	input  logic            redirect,
	input  simt_pkg::addr_t redirect_pc
);
	import simt_pkg::*;

	fetch_state_e state;
	addr_t        pc;
	addr_t        squash_pc; // restart point while the stale word drains

	assign f_cyc = (state != F_IDLE);
	assign f_stb = f_cyc;
	assign f_adr = pc; // pc only moves once the bus is idle

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= F_IDLE;
			pc          <= `RESET_PC;
			instr_valid <= 1'b0;
		end else begin
			if (redirect || instr_taken)
				instr_valid <= 1'b0;
			case (state)
				F_IDLE: begin
					if (redirect)
						pc <= redirect_pc;
					if (!instr_valid && !freeze)
						state <= F_REQ;
				end
				F_REQ: begin
					if (f_ack && !redirect) begin
						instr       <= f_dat_r;
						instr_pc    <= pc;
						instr_valid <= 1'b1;
						pc          <= pc + addr_t'(4);
						state       <= F_IDLE;
					end else if (f_ack) begin
						pc    <= redirect_pc; // word arrived on the wrong path
						state <= F_IDLE;
					end else if (redirect) begin
						squash_pc <= redirect_pc;
						state     <= F_SQUASH;
					end
				end
				F_SQUASH: begin
					if (f_ack) begin
						pc    <= squash_pc;
						state <= F_IDLE;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

endmodule

//--- simt_reg_file.sv
`timescale 1ns/100ps
`include "simt_defs.svh"

module simt_reg_file (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [4:0]                          rs1,
	input  logic [4:0]                          rs2,
	output simt_pkg::word_t [`NUM_THREADS-1:0] rd_data1,
	output simt_pkg::word_t [`NUM_THREADS-1:0] rd_data2,
	input  simt_pkg::lane_mask_t                wr_en,
	input  logic [4:0]                          wr_rd,
	input  simt_pkg::word_t [`NUM_THREADS-1:0] wr_data
);
	import simt_pkg::*;

	word_t regs [`NUM_THREADS][32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `NUM_THREADS; k++) begin
				for (int r = 0; r < 32; r++) begin
					regs[k][r] <= '0;
				end
			end
		end else begin
			for (int k = 0; k < `NUM_THREADS; k++) begin
				if (wr_en[k])
					regs[k][wr_rd] <= wr_data[k];
			end
		end
	end

	always_comb begin
		for (int k = 0; k < `NUM_THREADS; k++) begin
			rd_data1[k] = (rs1 == 5'd0) ? '0 : (rs1 == `TID_REG) ? word_t'(k) : regs[k][rs1];
			rd_data2[k] = (rs2 == 5'd0) ? '0 : (rs2 == `TID_REG) ? word_t'(k) : regs[k][rs2];
		end
	end

endmodule

//--- simt_pkg.sv
`include "simt_defs.svh"

package simt_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [`NUM_THREADS-1:0] lane_mask_t;

	typedef enum logic [2:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} branch_e;

	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_LINK} wb_src_e;

	// execute sequencer, one bus access per lane
	typedef enum logic [1:0] {EX_RUN, EX_MEM_REQ, EX_MEM_NEXT} ex_state_e;

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_SQUASH} fetch_state_e;

endpackage

//--- simt_defs.svh
`ifndef SIMT_DEFS_SVH
`define SIMT_DEFS_SVH

// lanes sharing one instruction stream
`define NUM_THREADS 2

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// reads back the lane index in every lane
`define TID_REG 5'd31

`endif
